// File: files.f
+incdir+.
mem_pkg.sv
mem_req_decode.sv
mem_port_arbiter.sv
mem_bank.sv
mem_read_return.sv
mem_router_top.sv
tb_mem_router.sv

// File: mem_bank.sv
module mem_bank #(
   parameter int DEPTH = 256
) (
   input  logic               i_clk,
   input  logic               i_arst_n,
   input  mem_pkg::bank_req_t i_req,
   output mem_pkg::bank_rsp_t o_rsp
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   logic [7:0]       mem [DEPTH];
   logic [AW-1:0]    idx;
   logic             rd_en;
   logic             rsp_valid;
   mem_pkg::master_e rsp_master;
   logic [7:0]       rdata_q;

   assign idx   = i_req.offset[AW-1:0];
   assign rd_en = i_req.valid & ~i_req.wr;

   always_ff @(posedge i_clk) begin
      if (i_req.valid && i_req.wr)
         mem[idx] <= i_req.wdata;
      if (rd_en) begin
         rdata_q    <= mem[idx];
         rsp_master <= i_req.master;  // tag follows the data
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n)
         rsp_valid <= 1'b0;
      else
         rsp_valid <= rd_en;
   end

   assign o_rsp = '{valid: rsp_valid, master: rsp_master, rdata: rdata_q};

   // decode hands us offsets already relative to this bank
   a_offset_in_range: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      i_req.valid |-> i_req.offset < DEPTH);

endmodule

// File: mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// region bounds, LO inclusive and HI exclusive
// kept 32 bits wide so the top of lwram fits

`define MEM_CART_LO   32'h0000_0000
`define MEM_CART_HI   32'h0000_8000  // cartridge, treated as plain RAM

`define MEM_LCD_LO    32'h0000_8000
`define MEM_LCD_HI    32'h0000_A000

`define MEM_WRAM_LO   32'h0000_C000
`define MEM_WRAM_HI   32'h0000_E000

`define MEM_OAM_LO    32'h0000_FE00
`define MEM_OAM_HI    32'h0000_FEA0  // sprite attribute table

`define MEM_IOREG_LO  32'h0000_FF00
`define MEM_IOREG_HI  32'h0000_FF80

`define MEM_LWRAM_LO  32'h0000_FF80
`define MEM_LWRAM_HI  32'h0001_0000

// byte handed back for a CPU read of a hole in the map
`define MEM_UNMAPPED_DATA 8'hFF

`endif

// File: mem_pkg.sv
package mem_pkg;

   // encoding order matters: the arbiter lets higher values win
   typedef enum logic [1:0] {
      M_CPU  = 2'd0,
      M_PPU  = 2'd1,
      M_RDMA = 2'd2,
      M_WDMA = 2'd3
   } master_e;

   // one value per bank, R_NONE for the holes
   typedef enum logic [2:0] {
      R_CART  = 3'd0,
      R_LCD   = 3'd1,
      R_WRAM  = 3'd2,
      R_OAM   = 3'd3,
      R_IOREG = 3'd4,
      R_LWRAM = 3'd5,
      R_NONE  = 3'd6
   } region_e;

   // raw master request, strobes active low as on the old bus
   typedef struct packed {
      logic        re_n;
      logic        we_n;
      logic [15:0] addr;
      logic [7:0]  wdata;
   } mem_req_t;

   typedef struct packed {
      logic        valid;
      logic        rd;
      logic        wr;
      region_e     region;
      master_e     master;
      logic [15:0] offset;  // address minus region base
      logic [7:0]  wdata;
   } dec_req_t;

   typedef struct packed {
      logic        valid;
      logic        wr;
      master_e     master;
      logic [15:0] offset;
      logic [7:0]  wdata;
   } bank_req_t;

   typedef struct packed {
      logic        valid;
      master_e     master;  // who gets the byte
      logic [7:0]  rdata;
   } bank_rsp_t;

   typedef struct packed {
      logic        rvalid;
      logic [7:0]  rdata;
   } mem_rsp_t;

endpackage

// File: mem_port_arbiter.sv
module mem_port_arbiter (
   input  logic               i_clk,
   input  logic               i_arst_n,
   input  mem_pkg::dec_req_t  i_dec [4],
   output mem_pkg::bank_req_t o_bank_req [6],
   output mem_pkg::dec_req_t  o_none_req,
   output logic               o_same_port_error
);

   logic [3:0]         req_vec [6];  // per region, one bit per master
   logic [1:0]         win [6];
   logic [5:0]         collide;
   mem_pkg::bank_req_t bank_d [6];
   mem_pkg::dec_req_t  none_d;

   always_comb begin
      for (int r = 0; r < 6; r++) begin
         req_vec[r] = '0;
         win[r]     = '0;
         for (int m = 0; m < 4; m++) begin
            req_vec[r][m] = i_dec[m].valid && i_dec[m].region == mem_pkg::region_e'(r);
            if (req_vec[r][m])
               win[r] = 2'(m);  // wdma > rdma > ppu > cpu by enum order
         end
         collide[r] = $countones(req_vec[r]) > 1;

         bank_d[r].valid  = |req_vec[r];
         bank_d[r].wr     = i_dec[win[r]].wr;
         bank_d[r].master = i_dec[win[r]].master;
         bank_d[r].offset = i_dec[win[r]].offset;
         bank_d[r].wdata  = i_dec[win[r]].wdata;
      end

      // only a cpu read can still be pointing at a hole here
      none_d       = i_dec[mem_pkg::M_CPU];
      none_d.valid = i_dec[mem_pkg::M_CPU].valid
                   && i_dec[mem_pkg::M_CPU].rd
                   && i_dec[mem_pkg::M_CPU].region == mem_pkg::R_NONE;
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_bank_req        <= '{default: '0};
         o_none_req        <= '0;
         o_same_port_error <= 1'b0;
      end else begin
         o_bank_req        <= bank_d;
         o_none_req        <= none_d;
         o_same_port_error <= |collide;  // one pulse no matter how many regions clash
      end
   end

   for (genvar r = 0; r < 6; r++) begin : g_grant_chk
      // the single winner asks for this region and no higher master does
      a_one_grant: assert property (@(posedge i_clk) disable iff (!i_arst_n)
         (|req_vec[r]) |-> (req_vec[r] >> win[r]) == 4'b0001);
   end

endmodule

// File: mem_read_return.sv
`include "mem_params.svh"

module mem_read_return (
   input  logic               i_clk,
   input  logic               i_arst_n,
   input  mem_pkg::bank_rsp_t i_bank_rsp [6],
   input  mem_pkg::dec_req_t  i_none_req,
   output mem_pkg::mem_rsp_t  o_cpu_rsp,
   output mem_pkg::mem_rsp_t  o_ppu_rsp,
   output mem_pkg::mem_rsp_t  o_rdma_rsp
);

   mem_pkg::mem_rsp_t rsp_d [3];  // cpu, ppu, rdma
   logic              wdma_tagged;

   always_comb begin
      wdma_tagged = 1'b0;
      for (int m = 0; m < 3; m++) begin
         rsp_d[m] = '0;
         for (int b = 0; b < 6; b++) begin
            if (i_bank_rsp[b].valid && i_bank_rsp[b].master == mem_pkg::master_e'(m))
               rsp_d[m] = '{rvalid: 1'b1, rdata: i_bank_rsp[b].rdata};
         end
      end

      // a cpu read of a hole, delayed to line up with the banks
      if (i_none_req.valid)
         rsp_d[mem_pkg::M_CPU] = '{rvalid: 1'b1, rdata: `MEM_UNMAPPED_DATA};

      for (int b = 0; b < 6; b++)
         wdma_tagged |= i_bank_rsp[b].valid && i_bank_rsp[b].master == mem_pkg::M_WDMA;
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_cpu_rsp  <= '0;
         o_ppu_rsp  <= '0;
         o_rdma_rsp <= '0;
      end else begin
         o_cpu_rsp  <= rsp_d[mem_pkg::M_CPU];
         o_ppu_rsp  <= rsp_d[mem_pkg::M_PPU];
         o_rdma_rsp <= rsp_d[mem_pkg::M_RDMA];
      end
   end

   // wdma is write only, decode must have stopped any read from it
   a_no_wdma_rsp: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      !wdma_tagged);

   a_none_is_cpu_read: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      i_none_req.valid |-> i_none_req.master == mem_pkg::M_CPU && i_none_req.rd);

endmodule

// File: mem_req_decode.sv
`include "mem_params.svh"

module mem_req_decode (
   input  logic              i_clk,
   input  logic              i_arst_n,
   input  mem_pkg::mem_req_t i_cpu_req,
   input  mem_pkg::mem_req_t i_ppu_req,
   input  mem_pkg::mem_req_t i_rdma_req,
   input  mem_pkg::mem_req_t i_wdma_req,
   output mem_pkg::dec_req_t o_dec [4],
   output logic              o_ppu_boundary_error,
   output logic              o_rdma_boundary_error,
   output logic              o_wdma_boundary_error
);

   mem_pkg::mem_req_t req [4];
   mem_pkg::dec_req_t dec_d [4];
   logic [3:0]        rule_ok;
   logic [3:0]        err_d;

   function automatic mem_pkg::region_e region_of(input logic [15:0] addr);
      if (addr >= `MEM_CART_LO && addr < `MEM_CART_HI) return mem_pkg::R_CART;
      if (addr >= `MEM_LCD_LO && addr < `MEM_LCD_HI) return mem_pkg::R_LCD;
      if (addr >= `MEM_WRAM_LO && addr < `MEM_WRAM_HI) return mem_pkg::R_WRAM;
      if (addr >= `MEM_OAM_LO && addr < `MEM_OAM_HI) return mem_pkg::R_OAM;
      if (addr >= `MEM_IOREG_LO && addr < `MEM_IOREG_HI) return mem_pkg::R_IOREG;
      if (addr >= `MEM_LWRAM_LO && addr < `MEM_LWRAM_HI) return mem_pkg::R_LWRAM;
      return mem_pkg::R_NONE;
   endfunction

   function automatic logic [15:0] base_of(input mem_pkg::region_e region);
      case (region)
         mem_pkg::R_CART:  return 16'(`MEM_CART_LO);
         mem_pkg::R_LCD:   return 16'(`MEM_LCD_LO);
         mem_pkg::R_WRAM:  return 16'(`MEM_WRAM_LO);
         mem_pkg::R_OAM:   return 16'(`MEM_OAM_LO);
         mem_pkg::R_IOREG: return 16'(`MEM_IOREG_LO);
         mem_pkg::R_LWRAM: return 16'(`MEM_LWRAM_LO);
         default:          return 16'h0000;  // unmapped keeps the full address
      endcase
   endfunction

   assign req[mem_pkg::M_CPU]  = i_cpu_req;
   assign req[mem_pkg::M_PPU]  = i_ppu_req;
   assign req[mem_pkg::M_RDMA] = i_rdma_req;
   assign req[mem_pkg::M_WDMA] = i_wdma_req;

   always_comb begin
      for (int m = 0; m < 4; m++) begin
         dec_d[m].rd     = ~req[m].re_n & req[m].we_n;
         dec_d[m].wr     = ~req[m].we_n;  // both strobes low counts as a write
         dec_d[m].region = region_of(req[m].addr);
         dec_d[m].master = mem_pkg::master_e'(m);
         dec_d[m].offset = req[m].addr - base_of(dec_d[m].region);
         dec_d[m].wdata  = req[m].wdata;
      end

      // cpu may go anywhere, an unmapped write just disappears
      rule_ok[mem_pkg::M_CPU] = dec_d[mem_pkg::M_CPU].rd
                              || dec_d[mem_pkg::M_CPU].region != mem_pkg::R_NONE;
      rule_ok[mem_pkg::M_PPU] = dec_d[mem_pkg::M_PPU].rd
                              && dec_d[mem_pkg::M_PPU].region inside
                                 {mem_pkg::R_LCD, mem_pkg::R_OAM};
      rule_ok[mem_pkg::M_RDMA] = dec_d[mem_pkg::M_RDMA].rd
                               && dec_d[mem_pkg::M_RDMA].region inside
                                  {mem_pkg::R_CART, mem_pkg::R_LCD, mem_pkg::R_WRAM};
      rule_ok[mem_pkg::M_WDMA] = dec_d[mem_pkg::M_WDMA].wr
                               && dec_d[mem_pkg::M_WDMA].region == mem_pkg::R_OAM;

      for (int m = 0; m < 4; m++) begin
         dec_d[m].valid = (dec_d[m].rd | dec_d[m].wr) & rule_ok[m];
         err_d[m]       = (dec_d[m].rd | dec_d[m].wr) & ~rule_ok[m];
      end
      err_d[mem_pkg::M_CPU] = 1'b0;  // no error line for the cpu
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_dec                 <= '{default: '0};
         o_ppu_boundary_error  <= 1'b0;
         o_rdma_boundary_error <= 1'b0;
         o_wdma_boundary_error <= 1'b0;
      end else begin
         o_dec                 <= dec_d;
         o_ppu_boundary_error  <= err_d[mem_pkg::M_PPU];
         o_rdma_boundary_error <= err_d[mem_pkg::M_RDMA];
         o_wdma_boundary_error <= err_d[mem_pkg::M_WDMA];
      end
   end

   // a ppu write strobe never makes it past decode, and is flagged
   a_ppu_no_write: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      !i_ppu_req.we_n |=> o_ppu_boundary_error && !o_dec[mem_pkg::M_PPU].valid);

endmodule

// File: mem_router_top.sv
`include "mem_params.svh"

module mem_router_top (
   input  logic              i_clk,
   input  logic              i_arst_n,
   input  mem_pkg::mem_req_t i_cpu_req,
   input  mem_pkg::mem_req_t i_ppu_req,
   input  mem_pkg::mem_req_t i_rdma_req,
   input  mem_pkg::mem_req_t i_wdma_req,
   output mem_pkg::mem_rsp_t o_cpu_rsp,
   output mem_pkg::mem_rsp_t o_ppu_rsp,
   output mem_pkg::mem_rsp_t o_rdma_rsp,
   output logic              o_same_port_error,
   output logic              o_ppu_boundary_error,
   output logic              o_rdma_boundary_error,
   output logic              o_wdma_boundary_error
);

   mem_pkg::dec_req_t  dec [4];
   mem_pkg::bank_req_t bank_req [6];
   mem_pkg::bank_rsp_t bank_rsp [6];
   mem_pkg::dec_req_t  none_req;
   mem_pkg::dec_req_t  none_q;  // unmapped read waiting out the bank cycle

   mem_req_decode u_decode (
      .i_clk                 (i_clk),
      .i_arst_n              (i_arst_n),
      .i_cpu_req             (i_cpu_req),
      .i_ppu_req             (i_ppu_req),
      .i_rdma_req            (i_rdma_req),
      .i_wdma_req            (i_wdma_req),
      .o_dec                 (dec),
      .o_ppu_boundary_error  (o_ppu_boundary_error),
      .o_rdma_boundary_error (o_rdma_boundary_error),
      .o_wdma_boundary_error (o_wdma_boundary_error)
   );

   mem_port_arbiter u_arbiter (
      .i_clk             (i_clk),
      .i_arst_n          (i_arst_n),
      .i_dec             (dec),
      .o_bank_req        (bank_req),
      .o_none_req        (none_req),
      .o_same_port_error (o_same_port_error)
   );

   mem_bank #(.DEPTH(`MEM_CART_HI - `MEM_CART_LO)) u_bank_cart (
      .i_clk (i_clk), .i_arst_n (i_arst_n),
      .i_req (bank_req[mem_pkg::R_CART]), .o_rsp (bank_rsp[mem_pkg::R_CART]));
   mem_bank #(.DEPTH(`MEM_LCD_HI - `MEM_LCD_LO)) u_bank_lcd (
      .i_clk (i_clk), .i_arst_n (i_arst_n),
      .i_req (bank_req[mem_pkg::R_LCD]), .o_rsp (bank_rsp[mem_pkg::R_LCD]));
   mem_bank #(.DEPTH(`MEM_WRAM_HI - `MEM_WRAM_LO)) u_bank_wram (
      .i_clk (i_clk), .i_arst_n (i_arst_n),
      .i_req (bank_req[mem_pkg::R_WRAM]), .o_rsp (bank_rsp[mem_pkg::R_WRAM]));
   mem_bank #(.DEPTH(`MEM_OAM_HI - `MEM_OAM_LO)) u_bank_oam (
      .i_clk (i_clk), .i_arst_n (i_arst_n),
      .i_req (bank_req[mem_pkg::R_OAM]), .o_rsp (bank_rsp[mem_pkg::R_OAM]));
   mem_bank #(.DEPTH(`MEM_IOREG_HI - `MEM_IOREG_LO)) u_bank_ioreg (
      .i_clk (i_clk), .i_arst_n (i_arst_n),
      .i_req (bank_req[mem_pkg::R_IOREG]), .o_rsp (bank_rsp[mem_pkg::R_IOREG]));
   mem_bank #(.DEPTH(`MEM_LWRAM_HI - `MEM_LWRAM_LO)) u_bank_lwram (
      .i_clk (i_clk), .i_arst_n (i_arst_n),
      .i_req (bank_req[mem_pkg::R_LWRAM]), .o_rsp (bank_rsp[mem_pkg::R_LWRAM]));

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n)
         none_q <= '0;
      else
         none_q <= none_req;
   end

   mem_read_return u_return (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_bank_rsp (bank_rsp),
      .i_none_req (none_q),
      .o_cpu_rsp  (o_cpu_rsp),
      .o_ppu_rsp  (o_ppu_rsp),
      .o_rdma_rsp (o_rdma_rsp)
   );

endmodule

// File: tb_mem_router.sv
`include "mem_params.svh"

module tb_mem_router;

   typedef struct packed {
      logic              err_ppu;
      logic              err_rdma;
      logic              err_wdma;
      logic              same;
      mem_pkg::mem_rsp_t cpu;
      mem_pkg::mem_rsp_t ppu;
      mem_pkg::mem_rsp_t rdma;
   } exp_t;

   localparam mem_pkg::mem_req_t idle_req = {2'b11, 24'h0};

   logic              i_clk;
   logic              i_arst_n;
   mem_pkg::mem_req_t i_cpu_req;
   mem_pkg::mem_req_t i_ppu_req;
   mem_pkg::mem_req_t i_rdma_req;
   mem_pkg::mem_req_t i_wdma_req;
   mem_pkg::mem_rsp_t o_cpu_rsp;
   mem_pkg::mem_rsp_t o_ppu_rsp;
   mem_pkg::mem_rsp_t o_rdma_rsp;
   logic              o_same_port_error;
   logic              o_ppu_boundary_error;
   logic              o_rdma_boundary_error;
   logic              o_wdma_boundary_error;

   logic [7:0] model_mem [65536];
   exp_t       hist [5];  // hist[k] holds the prediction for the request k edges back
   int         err_count = 0;
   int         timeout_count = 0;
   int         check_count = 0;

   mem_router_top uut (
      .i_clk                 (i_clk),
      .i_arst_n              (i_arst_n),
      .i_cpu_req             (i_cpu_req),
      .i_ppu_req             (i_ppu_req),
      .i_rdma_req            (i_rdma_req),
      .i_wdma_req            (i_wdma_req),
      .o_cpu_rsp             (o_cpu_rsp),
      .o_ppu_rsp             (o_ppu_rsp),
      .o_rdma_rsp            (o_rdma_rsp),
      .o_same_port_error     (o_same_port_error),
      .o_ppu_boundary_error  (o_ppu_boundary_error),
      .o_rdma_boundary_error (o_rdma_boundary_error),
      .o_wdma_boundary_error (o_wdma_boundary_error)
   );

   initial begin
      i_clk = 1'b0;
      forever #4 i_clk = ~i_clk;
   end

   initial begin
      i_arst_n = 1'b0;
      repeat (8) @(posedge i_clk);
      @(negedge i_clk);
      i_arst_n = 1'b1;
   end

   function automatic logic [31:0] region_bound(input int g, input logic top);
      case (g)
         mem_pkg::R_CART:  return top ? `MEM_CART_HI : `MEM_CART_LO;
         mem_pkg::R_LCD:   return top ? `MEM_LCD_HI : `MEM_LCD_LO;
         mem_pkg::R_WRAM:  return top ? `MEM_WRAM_HI : `MEM_WRAM_LO;
         mem_pkg::R_OAM:   return top ? `MEM_OAM_HI : `MEM_OAM_LO;
         mem_pkg::R_IOREG: return top ? `MEM_IOREG_HI : `MEM_IOREG_LO;
         mem_pkg::R_LWRAM: return top ? `MEM_LWRAM_HI : `MEM_LWRAM_LO;
         default:          return 32'h0;
      endcase
   endfunction

   function automatic int addr_region(input logic [15:0] addr);
      for (int g = 0; g < 6; g++)
         if (addr >= region_bound(g, 1'b0) && addr < region_bound(g, 1'b1))
            return g;
      return mem_pkg::R_NONE;
   endfunction

   // eight bytes at each end of a region
   function automatic logic [15:0] pool_addr(input int g, input int i);
      logic [31:0] lo;
      logic [31:0] hi;
      lo = region_bound(g, 1'b0);
      hi = region_bound(g, 1'b1);
      return (i < 8) ? 16'(lo + i) : 16'(hi - 16 + i);
   endfunction

   function automatic logic [15:0] hole_addr(input int i);
      case (i % 3)
         0:       return 16'hA000 + 16'(i);
         1:       return 16'hE000 + 16'(i * 37);
         default: return 16'hFEA0 + 16'(i % 96);
      endcase
   endfunction

   function automatic logic [7:0] fill_byte(input logic [15:0] addr);
      return addr[15:8] ^ {addr[6:0], addr[7]} ^ 8'ha5;
   endfunction

   function automatic mem_pkg::mem_req_t rd_req(input logic [15:0] addr);
      return {1'b0, 1'b1, addr, 8'h00};
   endfunction

   function automatic mem_pkg::mem_req_t wr_req(input logic [15:0] addr, input logic [7:0] d);
      return {1'b1, 1'b0, addr, d};
   endfunction

   function automatic mem_pkg::mem_req_t rand_req();
      mem_pkg::mem_req_t q;
      int                kind;
      kind    = $urandom % 4;  // idle, read, write, both strobes low
      q.re_n  = !(kind == 1 || kind == 3);
      q.we_n  = !(kind >= 2);
      q.addr  = ($urandom % 8 == 0) ? hole_addr($urandom % 128)
                                    : pool_addr($urandom % 6, $urandom % 16);
      q.wdata = $urandom;
      return q;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
      check_count++;
      if (got !== expected) begin
         err_count++;
         $display("ERR %0t %s got %0h expected %0h", $time, name, got, expected);
      end
   endtask

   task automatic match_rsp(input string name, input mem_pkg::mem_rsp_t got,
                            input mem_pkg::mem_rsp_t exp);
      check_val({name, ".rvalid"}, got.rvalid, exp.rvalid);
      if (exp.rvalid)
         check_val({name, ".rdata"}, got.rdata, exp.rdata);
   endtask

   task automatic scan_outputs();
      check_val("o_ppu_boundary_error", o_ppu_boundary_error, hist[1].err_ppu);
      check_val("o_rdma_boundary_error", o_rdma_boundary_error, hist[1].err_rdma);
      check_val("o_wdma_boundary_error", o_wdma_boundary_error, hist[1].err_wdma);
      check_val("o_same_port_error", o_same_port_error, hist[2].same);
      match_rsp("o_cpu_rsp", o_cpu_rsp, hist[4].cpu);
      match_rsp("o_ppu_rsp", o_ppu_rsp, hist[4].ppu);
      match_rsp("o_rdma_rsp", o_rdma_rsp, hist[4].rdma);
   endtask

   // reference model of one sampled cycle, index 0..3 is cpu, ppu, rdma, wdma
   task automatic predict(input mem_pkg::mem_req_t c, input mem_pkg::mem_req_t p,
                          input mem_pkg::mem_req_t r, input mem_pkg::mem_req_t w,
                          output exp_t e);
      mem_pkg::mem_req_t req [4];
      mem_pkg::mem_rsp_t rsp [4];
      int                reg_of [4];
      logic [3:0]        act;
      logic [3:0]        ok;
      int                win;
      int                cnt;
      req[0] = c;
      req[1] = p;
      req[2] = r;
      req[3] = w;
      e      = '0;
      for (int m = 0; m < 4; m++) begin
         act[m]    = !req[m].re_n || !req[m].we_n;
         reg_of[m] = addr_region(req[m].addr);
         rsp[m]    = '0;
      end
      ok[0] = req[0].we_n || reg_of[0] != mem_pkg::R_NONE;
      ok[1] = req[1].we_n && (reg_of[1] == mem_pkg::R_LCD || reg_of[1] == mem_pkg::R_OAM);
      ok[2] = req[2].we_n && (reg_of[2] == mem_pkg::R_CART || reg_of[2] == mem_pkg::R_LCD
                              || reg_of[2] == mem_pkg::R_WRAM);
      ok[3] = !req[3].we_n && reg_of[3] == mem_pkg::R_OAM;
      e.err_ppu  = act[1] && !ok[1];
      e.err_rdma = act[2] && !ok[2];
      e.err_wdma = act[3] && !ok[3];
      for (int g = 0; g < 6; g++) begin
         cnt = 0;
         win = -1;
         for (int m = 3; m >= 0; m--) begin  // wdma first, cpu last
            if (act[m] && ok[m] && reg_of[m] == g) begin
               cnt++;
               if (win < 0)
                  win = m;
            end
         end
         if (cnt > 1)
            e.same = 1'b1;
         if (win >= 0 && !req[win].we_n)
            model_mem[req[win].addr] = req[win].wdata;
         else if (win >= 0)
            rsp[win] = {1'b1, model_mem[req[win].addr]};
      end
      if (act[0] && req[0].we_n && reg_of[0] == mem_pkg::R_NONE)
         rsp[0] = {1'b1, `MEM_UNMAPPED_DATA};
      e.cpu  = rsp[0];
      e.ppu  = rsp[1];
      e.rdma = rsp[2];
   endtask

   task automatic step(input mem_pkg::mem_req_t c, input mem_pkg::mem_req_t p,
                       input mem_pkg::mem_req_t r, input mem_pkg::mem_req_t w);
      exp_t e;
      @(negedge i_clk);
      for (int k = 4; k > 0; k--)
         hist[k] = hist[k-1];
      scan_outputs();
      predict(c, p, r, w, e);
      hist[0]    = e;
      i_cpu_req  = c;
      i_ppu_req  = p;
      i_rdma_req = r;
      i_wdma_req = w;
   endtask

   function automatic logic pipe_busy();
      return |{hist[0], hist[1], hist[2], hist[3], hist[4]};
   endfunction

   initial begin
      int n;
      i_cpu_req  = idle_req;
      i_ppu_req  = idle_req;
      i_rdma_req = idle_req;
      i_wdma_req = idle_req;
      for (int k = 0; k < 5; k++)
         hist[k] = '0;
      n = $urandom(32'hdb76_cbf8);

      // outputs stay quiet while reset is held
      n = 0;
      while (i_arst_n !== 1'b1 && n < 32) begin
         @(posedge i_clk);
         if (i_arst_n !== 1'b1)
            scan_outputs();
         n++;
      end
      if (n >= 32) begin
         timeout_count++;
         $display("timeout: reset was not released within 32 cycles");
      end

      for (int g = 0; g < 6; g++)
         for (int i = 0; i < 16; i++)
            step(wr_req(pool_addr(g, i), fill_byte(pool_addr(g, i))), idle_req, idle_req,
                 idle_req);
      for (int g = 0; g < 6; g++)
         for (int i = 0; i < 16; i++)
            step(rd_req(pool_addr(g, i)), idle_req, idle_req, idle_req);
      for (int i = 0; i < 6; i++)
         step(rd_req(hole_addr(i)), idle_req, idle_req, idle_req);

      // ppu legal reads, then reads and writes it is not allowed
      for (int i = 0; i < 16; i++) begin
         step(idle_req, rd_req(pool_addr(mem_pkg::R_LCD, i)), idle_req, idle_req);
         step(idle_req, rd_req(pool_addr(mem_pkg::R_OAM, i)), idle_req, idle_req);
      end
      for (int g = 0; g < 6; g++)
         step(idle_req, rd_req(pool_addr(g, 3)), idle_req, idle_req);
      step(idle_req, wr_req(pool_addr(mem_pkg::R_LCD, 2), 8'h3c), idle_req, idle_req);
      step(idle_req, rd_req(hole_addr(1)), idle_req, idle_req);
      step(rd_req(pool_addr(mem_pkg::R_LCD, 2)), idle_req, idle_req, idle_req);

      // dma copy of cart and wram bytes into oam
      for (int i = 0; i < 16; i++) begin
         step(idle_req, idle_req,
              rd_req(pool_addr((i % 2) ? mem_pkg::R_WRAM : mem_pkg::R_CART, i)), idle_req);
         n = 0;
         do begin
            step(idle_req, idle_req, idle_req, idle_req);
            n++;
         end while (!o_rdma_rsp.rvalid && n < 10);
         if (!o_rdma_rsp.rvalid) begin
            timeout_count++;
            $display("timeout: dma read data did not come back within 10 cycles");
         end
         step(idle_req, idle_req, idle_req, wr_req(pool_addr(mem_pkg::R_OAM, i), o_rdma_rsp.rdata));
      end
      for (int i = 0; i < 16; i++)
         step(rd_req(pool_addr(mem_pkg::R_OAM, i)), idle_req, idle_req, idle_req);
      step(idle_req, idle_req, idle_req, wr_req(pool_addr(mem_pkg::R_WRAM, 5), 8'hee));
      step(idle_req, idle_req, rd_req(pool_addr(mem_pkg::R_OAM, 0)), idle_req);
      step(rd_req(pool_addr(mem_pkg::R_WRAM, 5)), idle_req, idle_req, idle_req);

      // same-region fights and a cycle with four distinct regions
      step(rd_req(pool_addr(mem_pkg::R_OAM, 0)), rd_req(pool_addr(mem_pkg::R_OAM, 1)), idle_req,
           wr_req(pool_addr(mem_pkg::R_OAM, 2), 8'h77));
      step(wr_req(pool_addr(mem_pkg::R_LCD, 3), 8'h11), rd_req(pool_addr(mem_pkg::R_LCD, 3)),
           idle_req, idle_req);
      step(rd_req(pool_addr(mem_pkg::R_CART, 1)), idle_req, rd_req(pool_addr(mem_pkg::R_CART, 2)),
           idle_req);
      step(rd_req(pool_addr(mem_pkg::R_LCD, 4)), rd_req(pool_addr(mem_pkg::R_LCD, 5)),
           rd_req(pool_addr(mem_pkg::R_LCD, 6)), idle_req);
      step(rd_req(pool_addr(mem_pkg::R_IOREG, 0)), rd_req(pool_addr(mem_pkg::R_LCD, 0)),
           rd_req(pool_addr(mem_pkg::R_CART, 0)), wr_req(pool_addr(mem_pkg::R_OAM, 3), 8'h42));
      step(rd_req(pool_addr(mem_pkg::R_OAM, 2)), rd_req(pool_addr(mem_pkg::R_OAM, 3)), idle_req,
           idle_req);
      step(rd_req(pool_addr(mem_pkg::R_LCD, 3)), idle_req, idle_req, idle_req);

      repeat (3000)
         step(rand_req(), rand_req(), rand_req(), rand_req());

      n = 0;
      while (pipe_busy() && n < 10) begin
         step(idle_req, idle_req, idle_req, idle_req);
         n++;
      end
      if (pipe_busy()) begin
         timeout_count++;
         $display("timeout: pipeline did not drain within 10 cycles");
      end

      $display("errors %0d, timeouts %0d, checks %0d", err_count, timeout_count, check_count);
      if (err_count == 0 && timeout_count == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule
